// File: project.f
rtl/asg_pkg.sv
rtl/asg_stream_if.sv
rtl/asg_ctl_if.sv
rtl/asg_regs.sv
rtl/asg_sequencer.sv
rtl/sample_fifo.sv
rtl/dac_formatter.sv
rtl/asg_top.sv
sim/asg_tb.sv

// File: rtl/asg_ctl_if.sv
// Configuration, command pulses and table writes toward the sequencer. CWN must not exceed 16.
`timescale 1ns/1ps
`default_nettype none

interface asg_ctl_if #(
  parameter int CWM = 8,
  parameter int CWF = 8,
  parameter int CWN = 16
);

  // periodic mode, fixed point CWM.CWF
  logic [CWM+CWF-1:0] siz;
  logic [CWM+CWF-1:0] ste;
  logic [CWM+CWF-1:0] off;
  // burst mode
  logic               ben;
  logic               inf;
  logic [CWN-1:0]     bdl;
  logic [CWN-1:0]     bpl;
  logic [CWN-1:0]     bnm;
  // single cycle commands
  logic               cmd_str;
  logic               cmd_stp;
  logic               cmd_trg;
  logic               cmd_rst;
  // table write port
  logic               tbl_we;
  logic [CWM-1:0]     tbl_addr;
  asg_pkg::sample_t   tbl_dat;
  // status back to the cpu
  logic               sts_run;
  logic [CWN-1:0]     sts_bln;
  logic [CWN-1:0]     sts_bnm;

  modport regs (
    output siz, ste, off, ben, inf, bdl, bpl, bnm,
    output cmd_str, cmd_stp, cmd_trg, cmd_rst,
    output tbl_we, tbl_addr, tbl_dat,
    input  sts_run, sts_bln, sts_bnm
  );

  modport seq (
    input  siz, ste, off, ben, inf, bdl, bpl, bnm,
    input  cmd_str, cmd_stp, cmd_trg, cmd_rst,
    input  tbl_we, tbl_addr, tbl_dat,
    output sts_run, sts_bln, sts_bnm
  );

endinterface

`default_nettype wire

// File: rtl/asg_pkg.sv
// Widths and register map of the waveform generator. Samples are fixed at 14 bits, APB at 32.
`default_nettype none

package asg_pkg;

  // basic widths
  localparam int SAMPLE_W = 14;
  localparam int WORD_W   = 32;
  localparam int APB_AW   = 12;

  // two's complement table sample
  typedef logic [SAMPLE_W-1:0] sample_t;
  // offset binary code for the DAC
  typedef logic [SAMPLE_W-1:0] dac_code_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [APB_AW-1:0]   apb_addr_t;

  //////////////////////////////////////////////////////////////////////////////
  // register map, byte offsets
  //////////////////////////////////////////////////////////////////////////////

  // wr: start, stop, sw trigger, channel reset / rd: running, sticky underrun
  localparam apb_addr_t REG_CTRL   = 12'h000;
  localparam apb_addr_t REG_SIZE   = 12'h004;
  localparam apb_addr_t REG_STEP   = 12'h008;
  localparam apb_addr_t REG_OFFSET = 12'h00C;
  // bit0 burst enable, bit1 infinite
  localparam apb_addr_t REG_BURST  = 12'h010;
  localparam apb_addr_t REG_BDL    = 12'h014;
  localparam apb_addr_t REG_BPL    = 12'h018;
  localparam apb_addr_t REG_BNM    = 12'h01C;
  // dac update divider
  localparam apb_addr_t REG_DIV    = 12'h020;
  // burst status, number counter in the high half
  localparam apb_addr_t REG_BSTS   = 12'h024;
  // table words from here on, write only
  localparam apb_addr_t TABLE_BASE = 12'h400;

  // sequencer run states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_RUN,
    ST_LAST
  } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/asg_regs.sv
// APB slave without wait states. Table words are write only and read back as zero, CWM <= 8.
`timescale 1ns/1ps
`default_nettype none

module asg_regs #(
  parameter int CWM = 8,
  parameter int CWF = 8,
  parameter int CWN = 16
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // apb slave
  input  asg_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  asg_pkg::word_t     pwdata,
  output asg_pkg::word_t     prdata,
  output logic               pready,
  output logic               pslverr,
  // formatter side
  input  logic               underrun,
  output asg_pkg::word_t     div,
  asg_ctl_if.regs            ctl
);

  localparam int PW = CWM + CWF;

  logic                      acc;
  logic                      wr_en;
  logic                      wr_ctrl;
  logic                      reg_hit;
  logic                      tbl_hit;
  logic [asg_pkg::APB_AW:0]  tbl_ofs;
  asg_pkg::word_t            rdat;
  logic                      und_stk;

  ////////////////////////////////////////////////////////////////////////////
  // access decode
  ////////////////////////////////////////////////////////////////////////////

  assign acc     = psel & penable;
  assign wr_en   = acc & pwrite;
  assign wr_ctrl = wr_en & (paddr == asg_pkg::REG_CTRL);

  // table window, borrow bit means below the base
  assign tbl_ofs = {1'b0, paddr} - {1'b0, asg_pkg::TABLE_BASE};
  assign tbl_hit = ~tbl_ofs[asg_pkg::APB_AW] & ((tbl_ofs[asg_pkg::APB_AW-1:2] >> CWM) == '0);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = acc & ~(reg_hit | tbl_hit);
  assign prdata  = acc ? rdat : '0;

  // table writes go straight to the sequencer RAM
  assign ctl.tbl_we   = wr_en & tbl_hit;
  assign ctl.tbl_addr = paddr[2 +: CWM];
  assign ctl.tbl_dat  = asg_pkg::sample_t'(pwdata[asg_pkg::SAMPLE_W-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ctl.siz <= '0;
      ctl.ste <= '0;
      ctl.off <= '0;
      ctl.ben <= 1'b0;
      ctl.inf <= 1'b0;
      ctl.bdl <= '0;
      ctl.bpl <= '0;
      ctl.bnm <= '0;
      div     <= '0;
    end else if (wr_en) begin
      case (paddr)
        asg_pkg::REG_SIZE:   ctl.siz <= pwdata[PW-1:0];
        asg_pkg::REG_STEP:   ctl.ste <= pwdata[PW-1:0];
        asg_pkg::REG_OFFSET: ctl.off <= pwdata[PW-1:0];
        asg_pkg::REG_BURST: begin
          ctl.ben <= pwdata[0];
          ctl.inf <= pwdata[1];
        end
        asg_pkg::REG_BDL:    ctl.bdl <= pwdata[CWN-1:0];
        asg_pkg::REG_BPL:    ctl.bpl <= pwdata[CWN-1:0];
        asg_pkg::REG_BNM:    ctl.bnm <= pwdata[CWN-1:0];
        asg_pkg::REG_DIV:    div     <= pwdata;
        default: ;
      endcase
    end
  end

  // command pulses, one cycle after the access edge
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ctl.cmd_str <= 1'b0;
      ctl.cmd_stp <= 1'b0;
      ctl.cmd_trg <= 1'b0;
      ctl.cmd_rst <= 1'b0;
    end else begin
      ctl.cmd_str <= wr_ctrl & pwdata[0];
      ctl.cmd_stp <= wr_ctrl & pwdata[1];
      ctl.cmd_trg <= wr_ctrl & pwdata[2];
      ctl.cmd_rst <= wr_ctrl & pwdata[3];
    end
  end

  // sticky underrun, cleared by channel reset
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      und_stk <= 1'b0;
    end else if (wr_ctrl & pwdata[3]) begin
      und_stk <= 1'b0;
    end else if (underrun) begin
      und_stk <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_hit = 1'b1;
    rdat    = '0;
    case (paddr)
      asg_pkg::REG_CTRL:   rdat = {30'd0, und_stk, ctl.sts_run};
      asg_pkg::REG_SIZE:   rdat = asg_pkg::word_t'(ctl.siz);
      asg_pkg::REG_STEP:   rdat = asg_pkg::word_t'(ctl.ste);
      asg_pkg::REG_OFFSET: rdat = asg_pkg::word_t'(ctl.off);
      asg_pkg::REG_BURST:  rdat = {30'd0, ctl.inf, ctl.ben};
      asg_pkg::REG_BDL:    rdat = asg_pkg::word_t'(ctl.bdl);
      asg_pkg::REG_BPL:    rdat = asg_pkg::word_t'(ctl.bpl);
      asg_pkg::REG_BNM:    rdat = asg_pkg::word_t'(ctl.bnm);
      asg_pkg::REG_DIV:    rdat = div;
      asg_pkg::REG_BSTS:   rdat = {16'(ctl.sts_bnm), 16'(ctl.sts_bln)};
      default:             reg_hit = 1'b0;
    endcase
  end

  // apb protocol, access phase only inside a selected transfer
  a_penable_psel: assert property (@(posedge sto) disable iff (ctl_rst)
    penable |-> psel);

endmodule

`default_nettype wire

// File: rtl/asg_sequencer.sv
// Table sequencer. Keep off below siz+1 and ste+1 at most siz+1 so the index stays in the table.
`timescale 1ns/1ps
`default_nettype none

module asg_sequencer #(
  parameter int CWM = 8,
  parameter int CWF = 8,
  parameter int CWN = 16
) (
  input  logic        sto,
  input  logic        ctl_rst,
  asg_ctl_if.seq      ctl,
  // external trigger pulse
  input  logic        trg,
  asg_stream_if.src   out
);

  localparam int PW = CWM + CWF;

  asg_pkg::sample_t    mem [2**CWM];
  asg_pkg::seq_state_e state;

  // fractional pointer
  logic [PW-1:0]  ptr;
  logic [PW:0]    ptr_add;
  logic [PW:0]    ptr_sub;
  logic [PW-1:0]  ptr_nxt;
  logic [CWM-1:0] rd_addr;
  // burst counters
  logic [CWN-1:0] bln;
  logic [CWN-1:0] bnm;
  // control
  logic           run_go;
  logic           sts_rdy;
  logic           issue;
  logic           dat_beat;
  logic           end_bpl;
  logic           end_bnm;
  logic           run_end;
  logic           stp_req;

  ////////////////////////////////////////////////////////////////////////////
  // table RAM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl.tbl_we) begin
      mem[ctl.tbl_addr] <= ctl.tbl_dat;
    end
  end

  // read register doubles as output data
  // idle beats keep the last sample
  always_ff @(posedge sto) begin
    if (issue & dat_beat) begin
      out.dat <= mem[rd_addr];
    end
  end

  assign rd_addr = ptr[CWF +: CWM];

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  // trigger counts when armed or with start
  assign run_go  = (trg | ctl.cmd_trg) &
                   ((state == asg_pkg::ST_ARMED) | ((state == asg_pkg::ST_IDLE) & ctl.cmd_str));
  // output register free or draining
  assign sts_rdy = out.rdy | ~out.vld;
  assign issue   = (state == asg_pkg::ST_RUN) & sts_rdy;

  // burst bookkeeping
  assign dat_beat = ~ctl.ben | (bln <= ctl.bdl);
  assign end_bpl  = ctl.ben & (bln == ctl.bpl);
  assign end_bnm  = end_bpl & (bnm == ctl.bnm) & ~ctl.inf;
  assign run_end  = ctl.cmd_stp | stp_req | end_bnm;

  always_ff @(posedge sto) begin
    if (ctl_rst | ctl.cmd_rst) begin
      state <= asg_pkg::ST_IDLE;
    end else begin
      case (state)
        asg_pkg::ST_IDLE: begin
          if (run_go) begin
            state <= asg_pkg::ST_RUN;
          end else if (ctl.cmd_str) begin
            state <= asg_pkg::ST_ARMED;
          end
        end
        asg_pkg::ST_ARMED: begin
          if (ctl.cmd_stp) begin
            state <= asg_pkg::ST_IDLE;
          end else if (run_go) begin
            state <= asg_pkg::ST_RUN;
          end
        end
        // final beat goes out with lst
        asg_pkg::ST_RUN: begin
          if (issue & run_end) begin
            state <= asg_pkg::ST_LAST;
          end
        end
        // wait for the lst beat to leave
        asg_pkg::ST_LAST: begin
          if (sts_rdy) begin
            state <= asg_pkg::ST_IDLE;
          end
        end
        default: state <= asg_pkg::ST_IDLE;
      endcase
    end
  end

  // stop seen while stalled goes out with the next beat
  always_ff @(posedge sto) begin
    if (ctl_rst | ctl.cmd_rst | (state != asg_pkg::ST_RUN) | issue) begin
      stp_req <= 1'b0;
    end else if (ctl.cmd_stp) begin
      stp_req <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointer and burst counters
  ////////////////////////////////////////////////////////////////////////////

  // step, then wrap modulo siz+1
  assign ptr_add = {1'b0, ptr} + {1'b0, ctl.ste} + 1'b1;
  assign ptr_sub = ptr_add - {1'b0, ctl.siz} - 1'b1;
  assign ptr_nxt = ptr_sub[PW] ? ptr_add[PW-1:0] : ptr_sub[PW-1:0];

  // everything freezes while the output is stalled
  always_ff @(posedge sto) begin
    if (ctl_rst | ctl.cmd_rst) begin
      ptr <= '0;
      bln <= '0;
      bnm <= '0;
    end else if (run_go) begin
      ptr <= ctl.off;
      bln <= '0;
      bnm <= '0;
    end else if (issue) begin
      if (end_bpl) begin
        // new burst period restarts at the phase offset
        ptr <= ctl.off;
        bln <= '0;
        bnm <= bnm + 1'b1;
      end else begin
        if (dat_beat) begin
          ptr <= ptr_nxt;
        end
        if (ctl.ben) begin
          bln <= bln + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output handshake and status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst | ctl.cmd_rst) begin
      out.vld <= 1'b0;
      out.lst <= 1'b0;
    end else if (sts_rdy) begin
      out.vld <= issue;
      out.lst <= issue & run_end;
    end
  end

  assign ctl.sts_run = (state == asg_pkg::ST_RUN) | (state == asg_pkg::ST_LAST);
  assign ctl.sts_bln = bln;
  assign ctl.sts_bnm = bnm;

  // stalled beat holds its sample
  a_dat_stable: assert property (@(posedge sto) disable iff (ctl_rst | ctl.cmd_rst)
    (out.vld & ~out.rdy) |=> (out.vld & $stable(out.dat)));

  // index stays inside the programmed table
  a_addr_range: assert property (@(posedge sto) disable iff (ctl_rst | ctl.cmd_rst)
    (state == asg_pkg::ST_RUN) |-> (rd_addr <= ctl.siz[CWF +: CWM]));

endmodule

`default_nettype wire

// File: rtl/asg_stream_if.sv
// Sample stream with valid/ready; a raised vld holds with stable dat and lst until rdy.
`timescale 1ns/1ps
`default_nettype none

interface asg_stream_if;

  // payload
  asg_pkg::sample_t dat;
  logic             lst;
  // handshake
  logic             vld;
  logic             rdy;

  // driving side
  modport src (
    output dat, lst, vld,
    input  rdy
  );

  // receiving side
  modport snk (
    input  dat, lst, vld,
    output rdy
  );

endinterface

`default_nettype wire

// File: rtl/asg_top.sv
// Single channel waveform generator top. Everything runs on sto, CWN <= 16 and CWM+CWF <= 32.
`timescale 1ns/1ps
`default_nettype none

module asg_top #(
  parameter int CWM        = 8,
  parameter int CWF        = 8,
  parameter int CWN        = 16,
  parameter int FIFO_DEPTH = 8
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // apb slave
  input  asg_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  asg_pkg::word_t     pwdata,
  output asg_pkg::word_t     prdata,
  output logic               pready,
  output logic               pslverr,
  // external trigger pulse
  input  logic               trg,
  // dac
  output asg_pkg::dac_code_t dac_dat,
  output logic               dac_vld,
  output logic               dac_lst
);

  asg_pkg::word_t div;
  logic           underrun;

  asg_ctl_if #(.CWM(CWM), .CWF(CWF), .CWN(CWN)) ctl ();
  // sequencer to fifo
  asg_stream_if seq_s ();
  // fifo to formatter
  asg_stream_if dac_s ();

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  asg_regs #(
    .CWM (CWM),
    .CWF (CWF),
    .CWN (CWN)
  ) u_regs (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .underrun (underrun),
    .div      (div),
    .ctl      (ctl.regs)
  );

  asg_sequencer #(
    .CWM (CWM),
    .CWF (CWF),
    .CWN (CWN)
  ) u_seq (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .ctl     (ctl.seq),
    .trg     (trg),
    .out     (seq_s.src)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .in      (seq_s.snk),
    .out     (dac_s.src)
  );

  dac_formatter u_fmt (
    .sto      (sto),
    .ctl_rst  (ctl_rst),
    .div      (div),
    .in       (dac_s.snk),
    .dac_dat  (dac_dat),
    .dac_vld  (dac_vld),
    .dac_lst  (dac_lst),
    .underrun (underrun)
  );

endmodule

`default_nettype wire

// File: rtl/dac_formatter.sv
// DAC formatter, one update slot every div+1 cycles. A new div value applies after the current slot.
`timescale 1ns/1ps
`default_nettype none

module dac_formatter (
  input  logic               sto,
  input  logic               ctl_rst,
  input  asg_pkg::word_t     div,
  asg_stream_if.snk          in,
  output asg_pkg::dac_code_t dac_dat,
  output logic               dac_vld,
  output logic               dac_lst,
  output logic               underrun
);

  asg_pkg::word_t cnt;
  logic           slot;
  logic           acc;
  logic           busy;

  // update slot when the divider hits zero
  assign slot   = (cnt == '0);
  assign in.rdy = slot;
  assign acc    = slot & in.vld;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      cnt <= '0;
    end else begin
      cnt <= slot ? div : cnt - 1'b1;
    end
  end

  // msb flip gives offset binary
  // code holds between updates
  always_ff @(posedge sto) begin
    if (acc) begin
      dac_dat <= asg_pkg::dac_code_t'({~in.dat[asg_pkg::SAMPLE_W-1],
                                        in.dat[asg_pkg::SAMPLE_W-2:0]});
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      dac_vld  <= 1'b0;
      dac_lst  <= 1'b0;
      busy     <= 1'b0;
      underrun <= 1'b0;
    end else begin
      dac_vld  <= acc;
      dac_lst  <= acc & in.lst;
      // run open from first beat until lst
      if (acc) begin
        busy <= ~in.lst;
      end
      underrun <= slot & ~in.vld & busy;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_fifo.sv
// Sample FIFO with registered storage. A full FIFO takes no write, even with a read that cycle.
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic      sto,
  input  logic      ctl_rst,
  asg_stream_if.snk in,
  asg_stream_if.src out
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  // sample and lst storage
  asg_pkg::sample_t mem_dat [FIFO_DEPTH];
  logic             mem_lst [FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          wr;
  logic          rd;

  assign wr = in.vld & in.rdy;
  assign rd = out.vld & out.rdy;

  assign in.rdy  = (cnt != CW'(FIFO_DEPTH));
  assign out.vld = (cnt != '0);
  // head entry shows up the cycle after its write
  assign out.dat = mem_dat[rd_ptr];
  assign out.lst = mem_lst[rd_ptr];

  always_ff @(posedge sto) begin
    if (wr) begin
      mem_dat[wr_ptr] <= in.dat;
      mem_lst[wr_ptr] <= in.lst;
    end
  end

  // circular pointers and fill level
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // a write never lands on the unread head entry
  a_no_wr_full: assert property (@(posedge sto) disable iff (ctl_rst)
    wr |-> ((wr_ptr != rd_ptr) | (cnt == '0)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it.
# The exit status is the simulator's own, so a $fatal in the testbench fails the script.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module asg_tb \
  -f project.f \
  -o asg_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/asg_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0

// File: sim/asg_tb.sv
// Testbench for asg_top at default parameters (CWF 8); 32 random table words, needs timing support.
`timescale 1ns/1ps
`default_nettype none

module asg_tb;

  localparam int FRAC        = 8;
  localparam int TBL_N       = 32;
  // beats seen before a stop is sent
  localparam int RUN1_BEATS  = 40;
  localparam int RUN2_BEATS  = 60;
  localparam int STOP_SLACK  = 16;
  // burst shape for the burst runs
  localparam int B_BDL       = 3;
  localparam int B_BPL       = 6;
  localparam int B_BNM       = 2;
  localparam int BURST_BEATS = (B_BNM + 1) * (B_BPL + 1);
  localparam int MAX_DIV     = 5;
  localparam int TOTAL_BEATS = RUN1_BEATS + RUN2_BEATS + 2 * STOP_SLACK + 2 * BURST_BEATS;
  localparam int CYC_LIMIT   = TOTAL_BEATS * (MAX_DIV + 1) + 2000;

  // ctrl write bits
  localparam asg_pkg::word_t CMD_START = 32'h1;
  localparam asg_pkg::word_t CMD_STOP  = 32'h2;
  localparam asg_pkg::word_t CMD_TRIG  = 32'h4;

  logic               sto;
  logic               ctl_rst;
  asg_pkg::apb_addr_t paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  asg_pkg::word_t     pwdata;
  asg_pkg::word_t     prdata;
  logic               pready;
  logic               pslverr;
  logic               trg;
  asg_pkg::dac_code_t dac_dat;
  logic               dac_vld;
  logic               dac_lst;

  // shadow of the table contents
  asg_pkg::sample_t   tbl [TBL_N];
  // expected dac codes with their lst flags
  asg_pkg::dac_code_t exp_dat [$];
  bit                 exp_lst [$];
  // scoreboard state
  bit                 lst_known;
  bit                 got_lst;
  int                 rx_cnt;
  bit                 seen_vld;
  int                 last_vld_cyc;
  int                 div_cur;
  int                 cyc = 0;

  asg_top dut (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trg     (trg),
    .dac_dat (dac_dat),
    .dac_vld (dac_vld),
    .dac_lst (dac_lst)
  );

  // 8 ns clock
  initial begin
    sto = 1'b0;
    forever #4 sto = ~sto;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  // step by ste+1, wrap by subtracting siz+1 when that stays non-negative
  function automatic int step_ptr(input int p, input int siz, input int ste);
    int nxt;
    nxt = p + ste + 1;
    if (nxt >= siz + 1) begin
      nxt = nxt - (siz + 1);
    end
    return nxt;
  endfunction

  // fills the expected queues with lst only on the final burst beat
  function automatic void build_expected(input int siz, input int ste, input int off,
                                         input bit ben, input int nmax);
    int               p;
    int               bln;
    int               bn;
    bit               dat_beat;
    bit               end_bpl;
    bit               fin;
    asg_pkg::sample_t s;
    exp_dat.delete();
    exp_lst.delete();
    p   = off;
    bln = 0;
    bn  = 0;
    s   = '0;
    for (int k = 0; k < nmax; k++) begin
      dat_beat = !ben || (bln <= B_BDL);
      if (dat_beat) begin
        s = tbl[p >> FRAC];
      end
      end_bpl = ben && (bln == B_BPL);
      fin     = end_bpl && (bn == B_BNM);
      // offset binary is the sample with its sign bit flipped
      exp_dat.push_back(s ^ 14'h2000);
      exp_lst.push_back(fin);
      if (fin) begin
        break;
      end
      if (end_bpl) begin
        // next period restarts at the phase offset
        p   = off;
        bln = 0;
        bn  = bn + 1;
      end else begin
        if (dat_beat) begin
          p = step_ptr(p, siz, ste);
        end
        if (ben) begin
          bln = bln + 1;
        end
      end
    end
  endfunction

  // dac monitor against the expected queues
  always @(negedge sto) begin
    if (!ctl_rst && dac_vld) begin
      check_val("dac beat with nothing expected", exp_dat.size() != 0, 1);
      check_val("dac_dat", dac_dat, exp_dat[0]);
      if (lst_known) begin
        check_val("dac_lst", dac_lst, exp_lst[0]);
      end
      // update slots are div+1 cycles apart at least
      if (seen_vld) begin
        check_val("dac_vld spacing", (cyc - last_vld_cyc) >= (div_cur + 1), 1);
      end
      exp_dat.delete(0);
      exp_lst.delete(0);
      seen_vld     = 1'b1;
      last_vld_cyc = cyc;
      rx_cnt       = rx_cnt + 1;
      if (dac_lst) begin
        got_lst = 1'b1;
      end
    end
  end

  // run limit
  always @(posedge sto) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYC_LIMIT);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // apb access
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_write(input asg_pkg::apb_addr_t addr, input asg_pkg::word_t data,
                           input bit exp_err);
    @(negedge sto);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge sto);
    penable = 1'b1;
    // access edge
    @(posedge sto);
    check_val("pready on write", pready, 1);
    check_val("pslverr on write", pslverr, exp_err);
    @(negedge sto);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input asg_pkg::apb_addr_t addr, output asg_pkg::word_t data,
                          input bit exp_err);
    @(negedge sto);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge sto);
    penable = 1'b1;
    @(posedge sto);
    data = prdata;
    check_val("pslverr on read", pslverr, exp_err);
    @(negedge sto);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input asg_pkg::apb_addr_t addr, input asg_pkg::word_t exp);
    asg_pkg::word_t rd;
    apb_read(addr, rd, 1'b0);
    check_val("register readback", rd, exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic set_config(input int siz, input int ste, input int off, input bit ben,
                            input int div);
    apb_write(asg_pkg::REG_SIZE, asg_pkg::word_t'(siz), 1'b0);
    apb_write(asg_pkg::REG_STEP, asg_pkg::word_t'(ste), 1'b0);
    apb_write(asg_pkg::REG_OFFSET, asg_pkg::word_t'(off), 1'b0);
    apb_write(asg_pkg::REG_BURST, {31'd0, ben}, 1'b0);
    apb_write(asg_pkg::REG_BDL, B_BDL, 1'b0);
    apb_write(asg_pkg::REG_BPL, B_BPL, 1'b0);
    apb_write(asg_pkg::REG_BNM, B_BNM, 1'b0);
    apb_write(asg_pkg::REG_DIV, asg_pkg::word_t'(div), 1'b0);
    div_cur = div;
  endtask

  // periodic run ended by a stop command
  task automatic run_stopped(input int n_stop, input bit use_ext);
    asg_pkg::word_t rd;
    got_lst   = 1'b0;
    rx_cnt    = 0;
    lst_known = 1'b0;
    if (use_ext) begin
      // arm first, then a single cycle pulse on trg
      apb_write(asg_pkg::REG_CTRL, CMD_START, 1'b0);
      repeat (2) @(negedge sto);
      trg = 1'b1;
      @(negedge sto);
      trg = 1'b0;
    end else begin
      apb_write(asg_pkg::REG_CTRL, CMD_START | CMD_TRIG, 1'b0);
    end
    wait (rx_cnt >= n_stop);
    apb_write(asg_pkg::REG_CTRL, CMD_STOP, 1'b0);
    // beats past the model length show up as unexpected
    wait (got_lst);
    exp_dat.delete();
    exp_lst.delete();
    repeat (20) @(negedge sto);
    apb_read(asg_pkg::REG_CTRL, rd, 1'b0);
    check_val("running after stop", rd[0], 0);
    // the dac never keeps up less than the sequencer here
    check_val("underrun flag after stop", rd[1], 0);
  endtask

  task automatic run_burst();
    asg_pkg::word_t rd;
    got_lst   = 1'b0;
    rx_cnt    = 0;
    lst_known = 1'b1;
    apb_write(asg_pkg::REG_CTRL, CMD_START | CMD_TRIG, 1'b0);
    wait (got_lst);
    check_val("beats missing after lst", exp_dat.size(), 0);
    repeat (20) @(negedge sto);
    apb_read(asg_pkg::REG_CTRL, rd, 1'b0);
    check_val("running after burst", rd[0], 0);
    check_val("underrun flag after burst", rd[1], 0);
    // bnm+1 periods counted and the length counter back at zero
    read_check(asg_pkg::REG_BSTS, (B_BNM + 1) << 16);
  endtask

  initial begin
    asg_pkg::word_t rd;
    void'($urandom(32'h5dc2_8615));
    ctl_rst      = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    trg          = 1'b0;
    lst_known    = 1'b0;
    got_lst      = 1'b0;
    rx_cnt       = 0;
    seen_vld     = 1'b0;
    last_vld_cyc = 0;
    div_cur      = 0;
    repeat (5) @(posedge sto);
    @(negedge sto);
    ctl_rst = 1'b0;

    // random table
    for (int i = 0; i < TBL_N; i++) begin
      tbl[i] = asg_pkg::sample_t'($urandom);
      apb_write(asg_pkg::TABLE_BASE + asg_pkg::apb_addr_t'(4 * i),
                asg_pkg::word_t'(tbl[i]), 1'b0);
    end

    // registers all written first and read back after
    apb_write(asg_pkg::REG_SIZE, 32'hABCD_1234, 1'b0);
    apb_write(asg_pkg::REG_STEP, 32'h0000_00AB, 1'b0);
    apb_write(asg_pkg::REG_OFFSET, 32'h0000_0F0F, 1'b0);
    apb_write(asg_pkg::REG_BURST, 32'h0000_0007, 1'b0);
    apb_write(asg_pkg::REG_BDL, 32'h0000_0007, 1'b0);
    apb_write(asg_pkg::REG_BPL, 32'h0000_0009, 1'b0);
    apb_write(asg_pkg::REG_BNM, 32'h0000_BEEF, 1'b0);
    apb_write(asg_pkg::REG_DIV, 32'h0000_0004, 1'b0);
    read_check(asg_pkg::REG_SIZE, 32'h0000_1234);
    read_check(asg_pkg::REG_STEP, 32'h0000_00AB);
    read_check(asg_pkg::REG_OFFSET, 32'h0000_0F0F);
    read_check(asg_pkg::REG_BURST, 32'h0000_0003);
    read_check(asg_pkg::REG_BDL, 32'h0000_0007);
    read_check(asg_pkg::REG_BPL, 32'h0000_0009);
    read_check(asg_pkg::REG_BNM, 32'h0000_BEEF);
    read_check(asg_pkg::REG_DIV, 32'h0000_0004);
    // unmapped space and the write only table
    apb_write(12'h028, 32'h0000_0001, 1'b1);
    apb_read(12'h800, rd, 1'b1);
    apb_read(12'h3FC, rd, 1'b1);
    read_check(asg_pkg::TABLE_BASE + 12'h004, 32'h0);

    // periodic, 32 entries, step 3.0, offset 5.0
    set_config(16'h1FFF, 16'h02FF, 16'h0500, 1'b0, 0);
    build_expected(16'h1FFF, 16'h02FF, 16'h0500, 1'b0, RUN1_BEATS + STOP_SLACK);
    run_stopped(RUN1_BEATS, 1'b0);

    // 20 entries, step 1.75, offset 2.5, external trigger and a slower dac
    set_config(16'h13FF, 16'h01BF, 16'h0280, 1'b0, 2);
    build_expected(16'h13FF, 16'h01BF, 16'h0280, 1'b0, RUN2_BEATS + STOP_SLACK);
    run_stopped(RUN2_BEATS, 1'b1);

    // burst, 16 entries, step 1.5, offset 1.0
    set_config(16'h0FFF, 16'h017F, 16'h0100, 1'b1, 0);
    build_expected(16'h0FFF, 16'h017F, 16'h0100, 1'b1, BURST_BEATS + 1);
    run_burst();

    // same burst with DIV 5 so the fifo fills and stalls the sequencer
    set_config(16'h0FFF, 16'h017F, 16'h0100, 1'b1, MAX_DIV);
    build_expected(16'h0FFF, 16'h017F, 16'h0100, 1'b1, BURST_BEATS + 1);
    run_burst();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
